//--- hdl/cpu6502_cfg.svh
`ifndef CPU6502_CFG_SVH
`define CPU6502_CFG_SVH

// Bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// PC value after reset, no vector fetch
`define CPU_RESET_PC 16'h0200

`endif

//--- hdl/cpu6502_pkg.sv
`include "cpu6502_cfg.svh"

package cpu6502_pkg;

    // Supported opcodes with their 6502 encodings
    typedef enum logic [7:0] {
        LDA_IMM = 8'hA9,
        LDX_IMM = 8'hA2,
        LDY_IMM = 8'hA0,
        ADC_IMM = 8'h69,
        AND_IMM = 8'h29,
        ORA_IMM = 8'h09,
        EOR_IMM = 8'h49,
        STA_ZP  = 8'h85,
        STX_ZP  = 8'h86,
        TAX     = 8'hAA,
        TAY     = 8'hA8,
        INX     = 8'hE8,
        CLC     = 8'h18,
        SEC     = 8'h38,
        NOP     = 8'hEA,
        JMP_ABS = 8'h4C
    } opcode_e;

    typedef enum logic [1:0] {
        T0 = 2'd0,
        T1 = 2'd1,
        T2 = 2'd2
    } cycle_e;

    typedef enum logic [2:0] {
        ALU_SUM,
        ALU_AND,
        ALU_EOR,
        ALU_OR,
        ALU_PASS
    } alu_op_e;

    // Sources for the special bus
    typedef enum logic [1:0] {
        SEL_A,
        SEL_X,
        SEL_Y,
        SEL_DL
    } reg_sel_e;

    typedef struct packed {
        logic     pc_inc;
        logic     pc_load_abs;
        logic     dl_load;
        logic     addr_from_dl;
        logic     write_en;
        logic     write_sel;     // 0 stores A, 1 stores X
        alu_op_e  alu_op;
        reg_sel_e alu_a_sel;
        logic     alu_b_from_dl;
        logic     alu_one;
        logic     load_a;
        logic     load_x;
        logic     load_y;
        logic     upd_nz;
        logic     upd_cv;
        logic     set_c;
        logic     clr_c;
    } ctrl_t;

    typedef struct packed {
        logic [`CPU_DATA_W-1:0] a;
        logic [`CPU_DATA_W-1:0] x;
        logic [`CPU_DATA_W-1:0] y;
        logic [`CPU_DATA_W-1:0] p;
        logic [`CPU_ADDR_W-1:0] pc;
    } cpu_regs_t;

    typedef struct packed {
        opcode_e                ir;
        cycle_e                 cycle;
        logic [`CPU_ADDR_W-1:0] pc;
        logic [`CPU_DATA_W-1:0] dl;
        logic [`CPU_DATA_W-1:0] a;
        logic [`CPU_DATA_W-1:0] x;
        logic [`CPU_DATA_W-1:0] y;
        logic [`CPU_DATA_W-1:0] p;
        logic [`CPU_DATA_W-1:0] alu_out;
    } debug_t;

endpackage

//--- hdl/cpu6502_alu.sv
`timescale 1ns/10ps
`include "cpu6502_cfg.svh"

module cpu6502_alu (
    input  cpu6502_pkg::alu_op_e   i_op,
    input  logic [`CPU_DATA_W-1:0] i_a,
    input  logic [`CPU_DATA_W-1:0] i_b,
    input  logic                   i_carry,
    output logic [`CPU_DATA_W-1:0] o_result,
    output logic                   o_carry,
    output logic                   o_overflow
);
    import cpu6502_pkg::*;

    localparam int MSB = `CPU_DATA_W - 1;

    logic [`CPU_DATA_W:0] sum;

    // Binary add only, no decimal mode
    assign sum = {1'b0, i_a} + {1'b0, i_b} + {{`CPU_DATA_W{1'b0}}, i_carry};

    always_comb begin
        o_carry    = i_carry;
        o_overflow = 1'b0;
        case (i_op)
            ALU_SUM: begin
                o_result   = sum[MSB:0];
                o_carry    = sum[`CPU_DATA_W];
                // Same operand signs, different result sign
                o_overflow = (i_a[MSB] == i_b[MSB]) && (sum[MSB] != i_a[MSB]);
            end
            ALU_AND: o_result = i_a & i_b;
            ALU_EOR: o_result = i_a ^ i_b;
            ALU_OR:  o_result = i_a | i_b;
            default: o_result = i_b;
        endcase
    end

endmodule

//--- hdl/cpu6502_tcu.sv
`timescale 1ns/10ps
`include "cpu6502_cfg.svh"

module cpu6502_tcu (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [`CPU_DATA_W-1:0] i_data,
    input  cpu6502_pkg::cycle_e    i_cycle_next,
    output cpu6502_pkg::cycle_e    o_cycle,
    output cpu6502_pkg::opcode_e   o_ir,
    output logic                   o_sync
);
    import cpu6502_pkg::*;

    cycle_e  cycle_q;
    opcode_e ir_q;

    // Cycle state follows the decoder
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cycle_q <= T0;
        end else begin
            cycle_q <= i_cycle_next;
        end
    end

    // Opcode is captured at the end of the fetch cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ir_q <= NOP;
        end else if (cycle_q == T0) begin
            ir_q <= opcode_e'(i_data);
        end
    end

    assign o_cycle = cycle_q;
    assign o_ir    = ir_q;

    // High for every opcode fetch
    assign o_sync  = (cycle_q == T0);

endmodule

//--- hdl/cpu6502_decoder.sv
`timescale 1ns/10ps

module cpu6502_decoder (
    input  cpu6502_pkg::opcode_e i_ir,
    input  cpu6502_pkg::cycle_e  i_cycle,
    output cpu6502_pkg::cycle_e  o_cycle_next,
    output cpu6502_pkg::ctrl_t   o_ctrl
);
    import cpu6502_pkg::*;

    always_comb begin
        o_ctrl           = '0;
        o_ctrl.alu_op    = ALU_PASS;
        o_ctrl.alu_a_sel = SEL_A;
        o_cycle_next     = T0;

        case (i_cycle)
            T0: begin
                // Opcode fetch
                o_ctrl.pc_inc = 1'b1;
                o_cycle_next  = T1;
            end

            T1: begin
                case (i_ir)
                    LDA_IMM, LDX_IMM, LDY_IMM: begin
                        o_ctrl.pc_inc    = 1'b1;
                        o_ctrl.dl_load   = 1'b1;
                        o_ctrl.alu_a_sel = SEL_DL;
                        o_ctrl.alu_op    = ALU_PASS;
                        o_ctrl.load_a    = (i_ir == LDA_IMM);
                        o_ctrl.load_x    = (i_ir == LDX_IMM);
                        o_ctrl.load_y    = (i_ir == LDY_IMM);
                        o_ctrl.upd_nz    = 1'b1;
                    end
                    ADC_IMM, AND_IMM, ORA_IMM, EOR_IMM: begin
                        o_ctrl.pc_inc        = 1'b1;
                        o_ctrl.dl_load       = 1'b1;
                        o_ctrl.alu_a_sel     = SEL_A;
                        o_ctrl.alu_b_from_dl = 1'b1;
                        o_ctrl.load_a        = 1'b1;
                        o_ctrl.upd_nz        = 1'b1;
                        case (i_ir)
                            ADC_IMM: begin
                                o_ctrl.alu_op = ALU_SUM;
                                o_ctrl.upd_cv = 1'b1;
                            end
                            AND_IMM: o_ctrl.alu_op = ALU_AND;
                            ORA_IMM: o_ctrl.alu_op = ALU_OR;
                            default: o_ctrl.alu_op = ALU_EOR;
                        endcase
                    end
                    STA_ZP, STX_ZP, JMP_ABS: begin
                        // Operand byte into DL, finish in T2
                        o_ctrl.pc_inc  = 1'b1;
                        o_ctrl.dl_load = 1'b1;
                        o_cycle_next   = T2;
                    end
                    TAX, TAY: begin
                        o_ctrl.alu_a_sel = SEL_A;
                        o_ctrl.alu_op    = ALU_PASS;
                        o_ctrl.load_x    = (i_ir == TAX);
                        o_ctrl.load_y    = (i_ir == TAY);
                        o_ctrl.upd_nz    = 1'b1;
                    end
                    INX: begin
                        o_ctrl.alu_a_sel = SEL_X;
                        o_ctrl.alu_one   = 1'b1;
                        o_ctrl.alu_op    = ALU_SUM;
                        o_ctrl.load_x    = 1'b1;
                        o_ctrl.upd_nz    = 1'b1;
                    end
                    CLC: o_ctrl.clr_c = 1'b1;
                    SEC: o_ctrl.set_c = 1'b1;
                    // NOP and unknown opcodes only do the dummy read
                    default: begin
                    end
                endcase
            end

            T2: begin
                case (i_ir)
                    STA_ZP, STX_ZP: begin
                        o_ctrl.addr_from_dl = 1'b1;
                        o_ctrl.write_en     = 1'b1;
                        o_ctrl.write_sel    = (i_ir == STX_ZP);
                    end
                    JMP_ABS: o_ctrl.pc_load_abs = 1'b1;
                    default: begin
                    end
                endcase
            end

            default: o_cycle_next = T0;
        endcase
    end

endmodule

//--- hdl/cpu6502_datapath.sv
`timescale 1ns/10ps
`include "cpu6502_cfg.svh"

module cpu6502_datapath (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  cpu6502_pkg::ctrl_t     i_ctrl,
    input  logic [`CPU_DATA_W-1:0] i_data,
    output logic [`CPU_ADDR_W-1:0] o_address,
    output logic [`CPU_DATA_W-1:0] o_data,
    output logic                   o_rw,
    output cpu6502_pkg::cpu_regs_t o_regs,
    output logic [`CPU_DATA_W-1:0] o_dl,
    output logic [`CPU_DATA_W-1:0] o_alu_out
);
    import cpu6502_pkg::*;

    // Status bit positions
    localparam int P_C = 0;
    localparam int P_Z = 1;
    localparam int P_V = 6;
    localparam int P_N = 7;

    cpu_regs_t              regs_q;
    logic [`CPU_DATA_W-1:0] dl_q;
    logic [`CPU_DATA_W-1:0] sb;
    logic [`CPU_DATA_W-1:0] alu_b;
    logic [`CPU_DATA_W-1:0] alu_result;
    logic                   alu_carry_in;
    logic                   alu_carry;
    logic                   alu_overflow;

    // Special bus, DL here is the byte on the data bus this cycle
    always_comb begin
        case (i_ctrl.alu_a_sel)
            SEL_A:   sb = regs_q.a;
            SEL_X:   sb = regs_q.x;
            SEL_Y:   sb = regs_q.y;
            default: sb = i_data;
        endcase
    end

    // Operand B is the data bus, the constant one, or the special bus for moves
    always_comb begin
        if (i_ctrl.alu_b_from_dl) begin
            alu_b = i_data;
        end else if (i_ctrl.alu_one) begin
            alu_b = `CPU_DATA_W'(1);
        end else begin
            alu_b = sb;
        end
    end

    // Increments ignore the carry flag
    assign alu_carry_in = i_ctrl.alu_one ? 1'b0 : regs_q.p[P_C];

    cpu6502_alu u_alu (
        .i_op       (i_ctrl.alu_op),
        .i_a        (sb),
        .i_b        (alu_b),
        .i_carry    (alu_carry_in),
        .o_result   (alu_result),
        .o_carry    (alu_carry),
        .o_overflow (alu_overflow)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            regs_q.a  <= '0;
            regs_q.x  <= '0;
            regs_q.y  <= '0;
            regs_q.p  <= '0;
            regs_q.pc <= `CPU_RESET_PC;
        end else begin
            if (i_ctrl.pc_load_abs) begin
                regs_q.pc <= {i_data, dl_q};
            end else if (i_ctrl.pc_inc) begin
                regs_q.pc <= regs_q.pc + 1'b1;
            end

            if (i_ctrl.load_a) regs_q.a <= alu_result;
            if (i_ctrl.load_x) regs_q.x <= alu_result;
            if (i_ctrl.load_y) regs_q.y <= alu_result;

            if (i_ctrl.upd_nz) begin
                regs_q.p[P_N] <= alu_result[`CPU_DATA_W-1];
                regs_q.p[P_Z] <= (alu_result == '0);
            end
            if (i_ctrl.upd_cv) begin
                regs_q.p[P_C] <= alu_carry;
                regs_q.p[P_V] <= alu_overflow;
            end else if (i_ctrl.set_c) begin
                regs_q.p[P_C] <= 1'b1;
            end else if (i_ctrl.clr_c) begin
                regs_q.p[P_C] <= 1'b0;
            end
        end
    end

    // Operand latch for zero page and jump targets
    always_ff @(posedge i_clk) begin
        if (i_ctrl.dl_load) begin
            dl_q <= i_data;
        end
    end

    // Zero page address for stores, PC otherwise
    assign o_address = i_ctrl.addr_from_dl ? {{(`CPU_ADDR_W-`CPU_DATA_W){1'b0}}, dl_q}
                                           : regs_q.pc;
    assign o_data    = i_ctrl.write_sel ? regs_q.x : regs_q.a;
    assign o_rw      = ~i_ctrl.write_en;

    assign o_regs    = regs_q;
    assign o_dl      = dl_q;
    assign o_alu_out = alu_result;

endmodule

//--- hdl/cpu6502.sv
`timescale 1ns/10ps
`include "cpu6502_cfg.svh"

module cpu6502 (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic [`CPU_DATA_W-1:0] i_data,   // Read data, sampled in the same cycle
    output logic [`CPU_ADDR_W-1:0] o_address,
    output logic                   o_rw,     // 1 read, 0 write
    output logic [`CPU_DATA_W-1:0] o_data,
    output logic                   o_sync,
    output cpu6502_pkg::debug_t    o_debug
);
    import cpu6502_pkg::*;

    cycle_e                 cycle;
    cycle_e                 cycle_next;
    opcode_e                ir;
    ctrl_t                  ctrl;
    cpu_regs_t              regs;
    logic [`CPU_DATA_W-1:0] dl;
    logic [`CPU_DATA_W-1:0] alu_out;

    cpu6502_tcu u_tcu (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_data       (i_data),
        .i_cycle_next (cycle_next),
        .o_cycle      (cycle),
        .o_ir         (ir),
        .o_sync       (o_sync)
    );

    cpu6502_decoder u_decoder (
        .i_ir         (ir),
        .i_cycle      (cycle),
        .o_cycle_next (cycle_next),
        .o_ctrl       (ctrl)
    );

    cpu6502_datapath u_datapath (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_ctrl    (ctrl),
        .i_data    (i_data),
        .o_address (o_address),
        .o_data    (o_data),
        .o_rw      (o_rw),
        .o_regs    (regs),
        .o_dl      (dl),
        .o_alu_out (alu_out)
    );

    // Debug view of the core state
    assign o_debug = '{
        ir:      ir,
        cycle:   cycle,
        pc:      regs.pc,
        dl:      dl,
        a:       regs.a,
        x:       regs.x,
        y:       regs.y,
        p:       regs.p,
        alu_out: alu_out
    };

endmodule

//--- dv/cpu6502_asserts.sv
`timescale 1ns/10ps

module cpu6502_asserts (
    input logic                i_clk,
    input logic                i_rst_n,
    input logic                i_rw,
    input logic                i_sync,
    input cpu6502_pkg::cycle_e i_cycle
);
    import cpu6502_pkg::*;

    int errors = 0;

    // Opcode fetch is always a read
    fetch_is_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_sync |-> i_rw)
    else begin
        $error("write during an opcode fetch");
        errors++;
    end

    // Stores write only in their last cycle
    write_in_t2: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_rw |-> (i_cycle == T2))
    else begin
        $error("write outside T2");
        errors++;
    end

    no_t0_repeat: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_cycle == T0) |=> (i_cycle != T0))
    else begin
        $error("cycle went from T0 to T0");
        errors++;
    end

endmodule

bind cpu6502 cpu6502_asserts u_asserts (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_rw    (o_rw),
    .i_sync  (o_sync),
    .i_cycle (o_debug.cycle)
);

//--- dv/cpu6502_tb.sv
`timescale 1ns/10ps
`include "cpu6502_cfg.svh"

module cpu6502_tb;
    import cpu6502_pkg::*;

    localparam logic [`CPU_ADDR_W-1:0] RAND_BASE = `CPU_RESET_PC + 16'h0040;
    localparam int RAND_COUNT = 40;
    localparam int RUN_COUNT  = 80;
    localparam int WAIT_LIMIT = 20;

    // Status bits in the 6502 layout
    localparam int P_C = 0;
    localparam int P_Z = 1;
    localparam int P_V = 6;
    localparam int P_N = 7;

    // Expected effect of one instruction
    typedef struct packed {
        cpu_regs_t              regs;
        logic                   wr;
        logic [`CPU_ADDR_W-1:0] wr_addr;
        logic [`CPU_DATA_W-1:0] wr_data;
        logic [1:0]             len;
    } step_t;

    logic                   i_clk;
    logic                   i_rst_n;
    logic [`CPU_DATA_W-1:0] i_data;
    logic [`CPU_ADDR_W-1:0] o_address;
    logic                   o_rw;
    logic [`CPU_DATA_W-1:0] o_data;
    logic                   o_sync;
    debug_t                 o_debug;

    logic [`CPU_DATA_W-1:0] mem [0:(1 << `CPU_ADDR_W) - 1];
    logic [`CPU_ADDR_W-1:0] wr_addr_q [$];
    logic [`CPU_DATA_W-1:0] wr_data_q [$];
    logic                   wr_pend;
    logic [`CPU_ADDR_W-1:0] wr_pend_addr;
    logic [`CPU_DATA_W-1:0] wr_pend_data;
    integer                 seed;

    // Loads, transfers, flag cases, carry chain, stores and one unknown opcode
    logic [7:0] fixed_prog [32] = '{
        8'hA9, 8'h00, 8'hA2, 8'h80, 8'hA0, 8'h7F, 8'hA9, 8'hFF,
        8'hAA, 8'hA8, 8'hE8, 8'h18, 8'hA9, 8'h7F, 8'h69, 8'h01,
        8'h38, 8'h69, 8'hFF, 8'h69, 8'h00, 8'h29, 8'h0F, 8'h09,
        8'hF0, 8'h49, 8'hAA, 8'h85, 8'h10, 8'h86, 8'h11, 8'h02
    };

    // ADC weighted up for more carry chaining
    opcode_e pick_ops [12] = '{
        LDA_IMM, LDX_IMM, ADC_IMM, ADC_IMM, ADC_IMM, AND_IMM,
        ORA_IMM, EOR_IMM, CLC, SEC, TAX, STA_ZP
    };

    cpu6502 dut (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data    (i_data),
        .o_address (o_address),
        .o_rw      (o_rw),
        .o_data    (o_data),
        .o_sync    (o_sync),
        .o_debug   (o_debug)
    );

    assign i_data = mem[o_address];

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    // Write seen mid cycle and committed at the closing edge
    always @(negedge i_clk) begin
        wr_pend      = i_rst_n && !o_rw;
        wr_pend_addr = o_address;
        wr_pend_data = o_data;
    end

    always @(posedge i_clk) begin
        if (wr_pend) begin
            mem[wr_pend_addr] <= wr_pend_data;
            wr_addr_q.push_back(wr_pend_addr);
            wr_data_q.push_back(wr_pend_data);
        end
    end

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(string msg);
        $display("[FAIL] %0t %s", $time, msg);
        stop_run();
    endtask

    task automatic check_fetch(logic [`CPU_ADDR_W-1:0] exp_pc);
        if (o_address !== exp_pc || o_rw !== 1'b1) begin
            report_mismatch($sformatf("fetch at %h rw %b, expected %h rw 1",
                                      o_address, o_rw, exp_pc));
        end
    endtask

    task automatic check_regs(cpu_regs_t got, cpu_regs_t exp);
        if (got !== exp) begin
            report_mismatch($sformatf("regs a/x/y/p/pc %h, expected %h", got, exp));
        end
    endtask

    task automatic check_write(logic exp_wr, logic [`CPU_ADDR_W-1:0] exp_addr,
                               logic [`CPU_DATA_W-1:0] exp_data);
        logic [`CPU_ADDR_W-1:0] got_addr;
        logic [`CPU_DATA_W-1:0] got_data;
        if (wr_addr_q.size() != int'(exp_wr)) begin
            report_mismatch($sformatf("%0d writes, expected %0d", wr_addr_q.size(), exp_wr));
        end else if (exp_wr) begin
            got_addr = wr_addr_q.pop_front();
            got_data = wr_data_q.pop_front();
            if (got_addr !== exp_addr || got_data !== exp_data) begin
                report_mismatch($sformatf("write %h to %h, expected %h to %h",
                                          got_data, got_addr, exp_data, exp_addr));
            end
        end
    endtask

    task automatic check_length(int got, int exp);
        if (got != exp) begin
            report_mismatch($sformatf("instruction took %0d cycles, expected %0d", got, exp));
        end
    endtask

    // Counts cycles up to the next opcode fetch
    task automatic wait_sync(output int cycles);
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
        end while (o_sync !== 1'b1 && cycles < WAIT_LIMIT);
        if (o_sync !== 1'b1) begin
            $display("Timeout: no opcode fetch within %0d cycles", WAIT_LIMIT);
            stop_run();
        end
    endtask

    task automatic load_program();
        logic [`CPU_ADDR_W-1:0] ptr;
        opcode_e                op;
        for (int i = 0; i < (1 << `CPU_ADDR_W); i++) begin
            mem[i] = i[15:8] ^ i[7:0] ^ 8'h5A;
        end
        ptr = `CPU_RESET_PC;
        foreach (fixed_prog[i]) begin
            mem[ptr] = fixed_prog[i];
            ptr++;
        end
        mem[ptr]     = JMP_ABS;
        mem[ptr + 1] = RAND_BASE[7:0];
        mem[ptr + 2] = RAND_BASE[15:8];
        ptr = RAND_BASE;
        repeat (RAND_COUNT) begin
            op = pick_ops[$unsigned($random(seed)) % 12];
            mem[ptr] = op;
            ptr++;
            if (!(op inside {CLC, SEC, TAX})) begin
                mem[ptr] = 8'($random(seed));
                ptr++;
            end
        end
        // Park on a jump to itself
        mem[ptr]     = JMP_ABS;
        mem[ptr + 1] = ptr[7:0];
        mem[ptr + 2] = ptr[15:8];
    endtask

    // One instruction on the register snapshot and the memory image
    function automatic step_t ref_step(cpu_regs_t r);
        step_t      s;
        logic [7:0] op;
        logic [7:0] imm;
        int         usum;
        int         ssum;
        logic [7:0] res;
        logic       nz;
        op        = mem[r.pc];
        imm       = mem[r.pc + 16'd1];
        s         = '0;
        s.regs    = r;
        s.len     = 2'd2;
        s.regs.pc = r.pc + 16'd2;
        res       = imm;
        nz        = 1'b1;
        case (op)
            LDA_IMM: s.regs.a = imm;
            LDX_IMM: s.regs.x = imm;
            LDY_IMM: s.regs.y = imm;
            ADC_IMM: begin
                // Carry from the unsigned total, overflow from the signed range
                usum           = int'(r.a) + int'(imm) + int'(r.p[P_C]);
                ssum           = int'($signed(r.a)) + int'($signed(imm)) + int'(r.p[P_C]);
                res            = 8'(usum);
                s.regs.a       = res;
                s.regs.p[P_C]  = (usum > 255);
                s.regs.p[P_V]  = (ssum > 127) || (ssum < -128);
            end
            AND_IMM: begin
                res      = r.a & imm;
                s.regs.a = res;
            end
            ORA_IMM: begin
                res      = r.a | imm;
                s.regs.a = res;
            end
            EOR_IMM: begin
                res      = r.a ^ imm;
                s.regs.a = res;
            end
            STA_ZP, STX_ZP: begin
                s.len     = 2'd3;
                s.wr      = 1'b1;
                s.wr_addr = {8'h00, imm};
                s.wr_data = (op == STX_ZP) ? r.x : r.a;
                nz        = 1'b0;
            end
            JMP_ABS: begin
                s.len     = 2'd3;
                s.regs.pc = {mem[r.pc + 16'd2], imm};
                nz        = 1'b0;
            end
            TAX, TAY, INX: begin
                res       = (op == INX) ? r.x + 8'd1 : r.a;
                s.regs.pc = r.pc + 16'd1;
                if (op == TAY) begin
                    s.regs.y = res;
                end else begin
                    s.regs.x = res;
                end
            end
            default: begin
                // CLC, SEC, NOP and unknown opcodes
                s.regs.pc = r.pc + 16'd1;
                nz        = 1'b0;
                if (op == CLC) s.regs.p[P_C] = 1'b0;
                if (op == SEC) s.regs.p[P_C] = 1'b1;
            end
        endcase
        if (nz) begin
            s.regs.p[P_N] = res[7];
            s.regs.p[P_Z] = (res == 8'h00);
        end
        return s;
    endfunction

    initial begin
        cpu_regs_t exp_regs;
        cpu_regs_t dut_regs;
        step_t     exp_step;
        int        cycles;
        i_rst_n = 1'b0;
        wr_pend = 1'b0;
        seed    = 32'h18a1_03ce;
        load_program();
        exp_regs = '{a: '0, x: '0, y: '0, p: '0, pc: `CPU_RESET_PC};
        repeat (3) @(posedge i_clk);
        #1 i_rst_n = 1'b1;
        wait_sync(cycles);
        for (int n = 0; n < RUN_COUNT; n++) begin
            dut_regs = '{a: o_debug.a, x: o_debug.x, y: o_debug.y,
                         p: o_debug.p, pc: o_debug.pc};
            check_fetch(exp_regs.pc);
            check_regs(dut_regs, exp_regs);
            if (dut.u_asserts.errors != 0) begin
                $display("A bound assertion on the bus or the cycle sequence failed");
                stop_run();
            end
            exp_step = ref_step(exp_regs);
            wait_sync(cycles);
            check_length(cycles, int'(exp_step.len));
            check_write(exp_step.wr, exp_step.wr_addr, exp_step.wr_data);
            exp_regs = exp_step.regs;
        end
        if (dut.u_asserts.errors == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("A bound assertion on the bus or the cycle sequence failed");
            stop_run();
        end
    end

endmodule

//--- sources.f
+incdir+hdl
hdl/cpu6502_pkg.sv
hdl/cpu6502_alu.sv
hdl/cpu6502_tcu.sv
hdl/cpu6502_decoder.sv
hdl/cpu6502_datapath.sv
hdl/cpu6502.sv
dv/cpu6502_asserts.sv
dv/cpu6502_tb.sv

//--- Bender.yml
package:
  name: cpu6502

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cpu6502_pkg.sv
      - hdl/cpu6502_alu.sv
      - hdl/cpu6502_tcu.sv
      - hdl/cpu6502_decoder.sv
      - hdl/cpu6502_datapath.sv
      - hdl/cpu6502.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/cpu6502_asserts.sv
      - dv/cpu6502_tb.sv
